//--- sources.f
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/hazard_if.sv
source/pipe_latch.sv
source/fetch.sv
source/decode.sv
source/hazard_unit.sv
source/execute.sv
source/data_memory.sv
source/cpu_top.sv
test/tb_clock.sv
test/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= cpu_tb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)

//--- test/cpu_tb.sv
`timescale 1ns/1ns
/*
 * Testbench for the pipelined core: random programs, instruction-set
 * model, and writeback and store trace checks
 */
module cpu_tb;
   import cpu_isa_pkg::*;

   localparam int PROG_LEN    = 40;
   localparam int RUN_TIMEOUT = 1000;
   localparam int QUIET_CYC   = 20;

   logic       clk;
   logic       rst;
   logic       imem_load;
   imem_addr_t imem_addr;
   word_t      imem_data;
   logic       err;
   logic       halted;
   logic       wb_valid;
   reg_idx_t   wb_reg;
   word_t      wb_data;
   logic       st_valid;
   dmem_addr_t st_addr;
   word_t      st_data;

   integer     seed;
   word_t      prog [IMEM_DEPTH];
   // Mirrors the DUT data RAM, which keeps its contents across resets
   word_t      model_mem [DMEM_DEPTH];
   reg_idx_t   exp_wb_reg[$];
   word_t      exp_wb_data[$];
   dmem_addr_t exp_st_addr[$];
   word_t      exp_st_data[$];
   logic       exp_err;

   tb_clock clk0 (.clk(clk));

   cpu_top dut0 (
      .clk(clk), .rst(rst), .imem_load(imem_load), .imem_addr(imem_addr),
      .imem_data(imem_data), .err(err), .halted(halted), .wb_valid(wb_valid),
      .wb_reg(wb_reg), .wb_data(wb_data), .st_valid(st_valid),
      .st_addr(st_addr), .st_data(st_data)
   );

   task automatic stop_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_wb(input string name, input reg_idx_t exp_reg, input word_t exp_data,
                           input reg_idx_t act_reg, input word_t act_data);
      if (exp_reg !== act_reg || exp_data !== act_data) begin
         $display("[ERROR] %s: writeback expected r%0d=%h, actual r%0d=%h",
                  name, exp_reg, exp_data, act_reg, act_data);
         stop_run();
      end
   endtask

   task automatic check_store(input string name, input dmem_addr_t exp_addr,
                              input word_t exp_data, input dmem_addr_t act_addr,
                              input word_t act_data);
      if (exp_addr !== act_addr || exp_data !== act_data) begin
         $display("[ERROR] %s: store expected [%h]=%h, actual [%h]=%h",
                  name, exp_addr, exp_data, act_addr, act_data);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp_val, input logic act_val);
      if (exp_val !== act_val) begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp_val, act_val);
         stop_run();
      end
   endtask

   task automatic check_idle(input string name);
      check_flag({name, " wb_valid idle"}, 1'b0, wb_valid);
      check_flag({name, " st_valid idle"}, 1'b0, st_valid);
      check_flag({name, " halted idle"}, 1'b0, halted);
      check_flag({name, " err idle"}, 1'b0, err);
   endtask

   function automatic int rnd(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic word_t enc(input opcode_t op, input reg_idx_t a, input reg_idx_t b,
                                 input logic [5:0] low);
      return {op, a, b, low};
   endfunction

   // Kinds: 0 dense ALU, 1 memory, 2 branches, 3 illegal opcode, 4 mixed
   task automatic gen_program(input int kind);
      int         i;
      int         pick;
      int         nreg;
      logic       use_mem;
      logic       use_br;
      logic       ill_done;
      reg_idx_t   ra;
      reg_idx_t   rb;
      reg_idx_t   rd;
      logic [5:0] low;
      nreg     = (kind == 0) ? 4 : 8;
      use_mem  = (kind == 1 || kind >= 3);
      use_br   = (kind == 2 || kind == 4);
      ill_done = 1'b0;
      i = 0;
      while (i < PROG_LEN) begin
         ra   = reg_idx_t'(rnd(nreg));
         rb   = reg_idx_t'(rnd(nreg));
         rd   = reg_idx_t'(rnd(nreg));
         low  = 6'(rnd(64));
         pick = rnd(10);
         if (kind == 3 && !ill_done && i >= 20) begin
            prog[i]  = {4'(9 + rnd(6)), ra, rb, low};
            ill_done = 1'b1;
         end else if (use_br && pick == 0) begin
            // Clear a register, then branch on it
            prog[i] = enc(OP_SUB, ra, ra, {ra, 3'b000});
            i++;
            if (i < PROG_LEN) prog[i] = enc(OP_BEQZ, ra, 3'b000, 6'(rnd(4)));
         end else if (use_br && pick == 1) begin
            prog[i] = enc(OP_BEQZ, ra, 3'b000, 6'(rnd(4)));
         end else if (use_mem && pick == 2) begin
            prog[i] = enc(OP_ST, ra, rb, low);
         end else if (use_mem && pick == 3) begin
            // Load followed by a reader of the loaded register
            prog[i] = enc(OP_LD, ra, rb, low);
            i++;
            if (i < PROG_LEN) prog[i] = enc(OP_XOR, ra, rd, {rd, 3'b000});
         end else if (pick < 6) begin
            prog[i] = enc(OP_ADDI, ra, rb, low);
         end else begin
            prog[i] = enc(opcode_t'(4'(1 + rnd(4))), ra, rb, {rd, 3'b000});
         end
         i++;
      end
      for (i = PROG_LEN; i < IMEM_DEPTH; i++) begin
         prog[i] = enc(OP_HALT, 3'b000, 3'b000, 6'b000000);
      end
   endtask

   // Reference interpreter producing the expected traces
   task automatic run_model();
      word_t      r [NUM_REGS];
      imem_addr_t pc;
      imem_addr_t nxt;
      word_t      ins;
      word_t      imm;
      word_t      off;
      dmem_addr_t addr;
      reg_idx_t   a;
      reg_idx_t   b;
      reg_idx_t   d;
      logic       done;
      int         steps;
      for (int k = 0; k < NUM_REGS; k++) r[k] = '0;
      exp_wb_reg.delete();
      exp_wb_data.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
      exp_err = 1'b0;
      pc      = '0;
      done    = 1'b0;
      steps   = 0;
      while (!done) begin
         ins  = prog[pc];
         a    = ins[11:9];
         b    = ins[8:6];
         d    = ins[5:3];
         imm  = {{10{ins[5]}}, ins[5:0]};
         off  = {{7{ins[8]}}, ins[8:0]};
         addr = dmem_addr_t'(r[b] + imm);
         nxt  = pc + 8'd1;
         case (ins[15:12])
            OP_NOP: ;
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
               case (ins[15:12])
                  OP_ADD:  r[d] = r[a] + r[b];
                  OP_SUB:  r[d] = r[a] - r[b];
                  OP_AND:  r[d] = r[a] & r[b];
                  default: r[d] = r[a] ^ r[b];
               endcase
               exp_wb_reg.push_back(d);
               exp_wb_data.push_back(r[d]);
            end
            OP_ADDI, OP_LD: begin
               r[a] = (ins[15:12] == OP_LD) ? model_mem[addr] : r[b] + imm;
               exp_wb_reg.push_back(a);
               exp_wb_data.push_back(r[a]);
            end
            OP_ST: begin
               model_mem[addr] = r[a];
               exp_st_addr.push_back(addr);
               exp_st_data.push_back(r[a]);
            end
            OP_BEQZ: if (r[a] == '0) nxt = pc + 8'd1 + imem_addr_t'(off);
            OP_HALT: done = 1'b1;
            default: exp_err = 1'b1;
         endcase
         pc = nxt;
         steps++;
         if (steps > RUN_TIMEOUT) begin
            $display("Model did not reach HALT within %0d steps", RUN_TIMEOUT);
            stop_run();
         end
      end
   endtask

   task automatic run_test(input string name, input int kind);
      int cycles;
      gen_program(kind);
      run_model();
      // Program goes in while the core is held in reset
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         @(negedge clk);
         rst       = 1'b1;
         imem_load = 1'b1;
         imem_addr = imem_addr_t'(i);
         imem_data = prog[i];
      end
      @(negedge clk);
      imem_load = 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_idle({name, " reset"});
      end
      rst = 1'b0;
      @(negedge clk);
      check_idle({name, " after reset"});
      cycles = 0;
      while (!halted) begin
         if (wb_valid) begin
            if (exp_wb_reg.size() == 0) begin
               $display("%s: unexpected write to r%0d", name, wb_reg);
               stop_run();
            end
            check_wb(name, exp_wb_reg.pop_front(), exp_wb_data.pop_front(), wb_reg, wb_data);
         end
         if (st_valid) begin
            if (exp_st_addr.size() == 0) begin
               $display("%s: unexpected store to address %h", name, st_addr);
               stop_run();
            end
            check_store(name, exp_st_addr.pop_front(), exp_st_data.pop_front(),
                        st_addr, st_data);
         end
         if (cycles >= RUN_TIMEOUT) begin
            $display("%s: halted did not rise within %0d cycles", name, RUN_TIMEOUT);
            stop_run();
         end
         @(negedge clk);
         cycles++;
      end
      if (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
         $display("%s: core halted with %0d writes and %0d stores still missing",
                  name, exp_wb_reg.size(), exp_st_addr.size());
         stop_run();
      end
      repeat (QUIET_CYC) begin
         @(negedge clk);
         check_flag({name, " wb_valid after halt"}, 1'b0, wb_valid);
         check_flag({name, " st_valid after halt"}, 1'b0, st_valid);
         check_flag({name, " halted held"}, 1'b1, halted);
      end
      check_flag({name, " err"}, exp_err, err);
   endtask

   initial begin
      seed      = 99251;
      rst       = 1'b1;
      imem_load = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      for (int i = 0; i < DMEM_DEPTH; i++) model_mem[i] = '0;
      run_test("alu_forwarding", 0);
      run_test("load_store", 1);
      run_test("branches", 2);
      run_test("illegal_opcode", 3);
      // Also checks that reset clears the sticky err
      run_test("mixed", 4);
      $display("Test passed");
      $finish;
   end
endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns
/*
 * Testbench clock source, 8 ns period
 */
module tb_clock #(
   parameter int PERIOD = 8
) (
   output logic clk
);
   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;
endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ns
/*
 * Five-stage 16-bit pipelined core with writeback and store traces
 */
module cpu_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imem_load,
   input  cpu_isa_pkg::imem_addr_t imem_addr,
   input  cpu_isa_pkg::word_t      imem_data,
   output logic                    err,
   output logic                    halted,
   output logic                    wb_valid,
   output cpu_isa_pkg::reg_idx_t   wb_reg,
   output cpu_isa_pkg::word_t      wb_data,
   output logic                    st_valid,
   output cpu_isa_pkg::dmem_addr_t st_addr,
   output cpu_isa_pkg::word_t      st_data
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   if_id_t     if_id_d, if_id_q;
   id_ex_t     id_ex_d, id_ex_q;
   ex_mem_t    ex_mem_d, ex_mem_q;
   mem_wb_t    mem_wb_d, mem_wb_q;
   reg_idx_t   src_a;
   reg_idx_t   src_b;
   logic       is_halt;
   logic       redirect;
   imem_addr_t target;
   word_t      wb_value;
   logic       halt_now;
   logic       halted_q;

   hazard_if hz_if ();

   // HALT in decode stops fetch, unless a stall keeps it in place
   fetch fetch0 (
      .clk(clk), .rst(rst),
      .imem_load(imem_load), .imem_addr(imem_addr), .imem_data(imem_data),
      .hold(hz_if.stall || is_halt), .redirect(redirect), .target(target),
      .out(if_id_d)
   );

   pipe_latch #(.payload_t(if_id_t)) if_id_latch (
      .clk(clk), .rst(rst), .hold(hz_if.stall),
      .flush(redirect || (is_halt && !hz_if.stall)),
      .d(if_id_d), .q(if_id_q)
   );

   decode decode0 (
      .clk(clk), .rst(rst), .in(if_id_q), .wb(mem_wb_q), .wb_value(wb_value),
      .hz(hz_if.dec), .out(id_ex_d), .src_a(src_a), .src_b(src_b),
      .is_halt(is_halt), .err(err)
   );

   pipe_latch #(.payload_t(id_ex_t)) id_ex_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .flush(redirect),
      .d(id_ex_d), .q(id_ex_q)
   );

   execute execute0 (
      .in(id_ex_q), .mem_result(ex_mem_q.result), .wb_value(wb_value),
      .hz(hz_if.exec), .out(ex_mem_d), .redirect(redirect), .target(target)
   );

   pipe_latch #(.payload_t(ex_mem_t)) ex_mem_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
      .d(ex_mem_d), .q(ex_mem_q)
   );

   data_memory dmem0 (.clk(clk), .in(ex_mem_q), .out(mem_wb_d));

   pipe_latch #(.payload_t(mem_wb_t)) mem_wb_latch (
      .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
      .d(mem_wb_d), .q(mem_wb_q)
   );

   hazard_unit hazard0 (.hz(hz_if.unit));

   assign hz_if.id_ra     = src_a;
   assign hz_if.id_rb     = src_b;
   assign hz_if.ex_ra     = id_ex_q.ra;
   assign hz_if.ex_rb     = id_ex_q.rb;
   assign hz_if.ex_load   = id_ex_q.valid && id_ex_q.ctrl.mem_read;
   assign hz_if.ex_dest   = id_ex_q.ctrl.dest;
   assign hz_if.mem_dest  = ex_mem_q.ctrl.dest;
   assign hz_if.mem_write = ex_mem_q.valid && ex_mem_q.ctrl.reg_write;
   assign hz_if.wb_dest   = mem_wb_q.ctrl.dest;
   assign hz_if.wb_write  = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;

   // Writeback select
   assign wb_value = mem_wb_q.ctrl.mem_read ? mem_wb_q.load_val : mem_wb_q.result;

   assign halt_now = mem_wb_q.valid && mem_wb_q.ctrl.halt;

   always_ff @(posedge clk) begin
      if (rst) begin
         halted_q <= 1'b0;
      end else if (halt_now) begin
         halted_q <= 1'b1;
      end
   end

   assign halted = halted_q || halt_now;

   // Traces for the testbench
   assign wb_valid = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;
   assign wb_reg   = mem_wb_q.ctrl.dest;
   assign wb_data  = wb_value;
   assign st_valid = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;
   assign st_addr  = dmem_addr_t'(ex_mem_q.result);
   assign st_data  = ex_mem_q.store_val;
endmodule

//--- source/data_memory.sv
`timescale 1ns/1ns
/*
 * Data memory stage: word RAM, synchronous write, combinational read
 */
module data_memory (
   input  logic                  clk,
   input  cpu_pipe_pkg::ex_mem_t in,
   output cpu_pipe_pkg::mem_wb_t out
);
   import cpu_isa_pkg::*;

   word_t      mem [DMEM_DEPTH] = '{default: '0};
   dmem_addr_t addr;

   // Low bits of the computed address
   assign addr = dmem_addr_t'(in.result);

   always_ff @(posedge clk) begin
      if (in.valid && in.ctrl.mem_write) begin
         mem[addr] <= in.store_val;
      end
   end

   assign out = '{valid: in.valid, ctrl: in.ctrl, result: in.result, load_val: mem[addr]};
endmodule

//--- source/execute.sv
`timescale 1ns/1ns
/*
 * Execute stage: operand forwarding, ALU, address generation
 * and BEQZ resolution
 */
module execute (
   input  cpu_pipe_pkg::id_ex_t    in,
   input  cpu_isa_pkg::word_t      mem_result,
   input  cpu_isa_pkg::word_t      wb_value,
   hazard_if.exec                  hz,
   output cpu_pipe_pkg::ex_mem_t   out,
   output logic                    redirect,
   output cpu_isa_pkg::imem_addr_t target
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t op_a;
   word_t reg_b;
   word_t alu_a;
   word_t op_b;
   word_t alu_y;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
                                     input word_t mem_val, input word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return rf_val;
      endcase
   endfunction

   assign op_a  = fwd_mux(hz.fwd_a, in.a_val, mem_result, wb_value);
   assign reg_b = fwd_mux(hz.fwd_b, in.b_val, mem_result, wb_value);

   // Immediate forms use register b as the base
   assign alu_a = in.ctrl.use_imm ? reg_b : op_a;
   assign op_b  = in.ctrl.use_imm ? in.imm : reg_b;

   always_comb begin
      case (in.ctrl.alu_op)
         ALU_ADD: alu_y = alu_a + op_b;
         ALU_SUB: alu_y = alu_a - op_b;
         ALU_AND: alu_y = alu_a & op_b;
         ALU_XOR: alu_y = alu_a ^ op_b;
         default: alu_y = op_b;
      endcase
   end

   // Register a is the store data
   assign out = '{valid: in.valid, ctrl: in.ctrl, result: alu_y, store_val: op_a};

   assign redirect = in.valid && in.ctrl.branch && (op_a == '0);
   assign target   = in.pc + 1'b1 + imem_addr_t'(in.imm);
endmodule

//--- source/hazard_unit.sv
`timescale 1ns/1ns
/*
 * Hazard unit: load-use stall and forwarding selection
 */
module hazard_unit (
   hazard_if.unit hz
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   // Youngest writer wins
   function automatic fwd_sel_t pick_fwd(
      input reg_idx_t src,
      input logic     mem_write,
      input reg_idx_t mem_dest,
      input logic     wb_write,
      input reg_idx_t wb_dest
   );
      if (mem_write && mem_dest == src) begin
         return FWD_MEM;
      end else if (wb_write && wb_dest == src) begin
         return FWD_WB;
      end
      return FWD_RF;
   endfunction

   assign hz.fwd_a = pick_fwd(hz.ex_ra, hz.mem_write, hz.mem_dest, hz.wb_write, hz.wb_dest);
   assign hz.fwd_b = pick_fwd(hz.ex_rb, hz.mem_write, hz.mem_dest, hz.wb_write, hz.wb_dest);

   // Load result not ready until writeback, so wait one cycle
   assign hz.stall = hz.ex_load &&
                     (hz.ex_dest == hz.id_ra || hz.ex_dest == hz.id_rb);
endmodule

//--- source/decode.sv
`timescale 1ns/1ns
/*
 * Decode stage: control decode, register file with write bypass,
 * immediate sign extension and sticky illegal-opcode error
 */
module decode (
   input  logic                  clk,
   input  logic                  rst,
   input  cpu_pipe_pkg::if_id_t  in,
   input  cpu_pipe_pkg::mem_wb_t wb,
   input  cpu_isa_pkg::word_t    wb_value,
   hazard_if.dec                 hz,
   output cpu_pipe_pkg::id_ex_t  out,
   output cpu_isa_pkg::reg_idx_t src_a,
   output cpu_isa_pkg::reg_idx_t src_b,
   output logic                  is_halt,
   output logic                  err
);
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t    regs [NUM_REGS];
   opcode_t  opcode;
   reg_idx_t fld_d;
   ctrl_t    ctrl;
   logic     illegal;
   logic     wb_en;
   word_t    a_val;
   word_t    b_val;
   word_t    imm;
   logic     err_q;

   assign opcode = opcode_t'(in.instr[OP_LSB +: OP_W]);
   assign src_a  = in.instr[FA_LSB +: REG_W];
   assign src_b  = in.instr[FB_LSB +: REG_W];
   assign fld_d  = in.instr[FD_LSB +: REG_W];

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = ALU_PASS_B;
      ctrl.dest   = src_a;
      illegal     = 1'b0;
      case (opcode)
         OP_NOP: ctrl.alu_op = ALU_PASS_B;
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = fld_d;
            case (opcode)
               OP_SUB:  ctrl.alu_op = ALU_SUB;
               OP_AND:  ctrl.alu_op = ALU_AND;
               OP_XOR:  ctrl.alu_op = ALU_XOR;
               default: ctrl.alu_op = ALU_ADD;
            endcase
         end
         OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.use_imm   = 1'b1;
            ctrl.alu_op    = ALU_ADD;
         end
         OP_LD: begin
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.use_imm   = 1'b1;
            ctrl.alu_op    = ALU_ADD;
         end
         OP_ST: begin
            ctrl.mem_write = 1'b1;
            ctrl.use_imm   = 1'b1;
            ctrl.alu_op    = ALU_ADD;
         end
         OP_BEQZ: ctrl.branch = 1'b1;
         OP_HALT: ctrl.halt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   // Same-cycle writeback goes straight through to the reads
   assign wb_en = wb.valid && wb.ctrl.reg_write;
   assign a_val = (wb_en && wb.ctrl.dest == src_a) ? wb_value : regs[src_a];
   assign b_val = (wb_en && wb.ctrl.dest == src_b) ? wb_value : regs[src_b];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb.ctrl.dest] <= wb_value;
      end
   end

   // BEQZ carries a 9-bit offset, the rest a 6-bit immediate
   assign imm = (opcode == OP_BEQZ) ?
                {{(WORD_W - OFF_W){in.instr[OFF_W-1]}}, in.instr[OFF_W-1:0]} :
                {{(WORD_W - IMM_W){in.instr[IMM_W-1]}}, in.instr[IMM_W-1:0]};

   // Stall sends a bubble down to execute
   always_comb begin
      out = '0;
      if (in.valid && !hz.stall) begin
         out.valid = 1'b1;
         out.pc    = in.pc;
         out.ctrl  = ctrl;
         out.ra    = src_a;
         out.rb    = src_b;
         out.a_val = a_val;
         out.b_val = b_val;
         out.imm   = imm;
      end
   end

   assign is_halt = in.valid && (opcode == OP_HALT);

   always_ff @(posedge clk) begin
      if (rst) begin
         err_q <= 1'b0;
      end else if (in.valid && illegal) begin
         err_q <= 1'b1;
      end
   end

   assign err = err_q || (in.valid && illegal);
endmodule

//--- source/fetch.sv
`timescale 1ns/1ns
/*
 * Fetch stage: program counter, loadable instruction memory
 * and branch redirect
 */
module fetch (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imem_load,
   input  cpu_isa_pkg::imem_addr_t imem_addr,
   input  cpu_isa_pkg::word_t      imem_data,
   input  logic                    hold,
   input  logic                    redirect,
   input  cpu_isa_pkg::imem_addr_t target,
   output cpu_pipe_pkg::if_id_t    out
);
   import cpu_isa_pkg::*;

   word_t      imem [IMEM_DEPTH];
   imem_addr_t pc;
   word_t      instr;
   logic       at_halt;

   // Loaded while the core sits in reset
   always_ff @(posedge clk) begin
      if (imem_load) begin
         imem[imem_addr] <= imem_data;
      end
   end

   assign instr   = imem[pc];
   assign at_halt = (opcode_t'(instr[OP_LSB +: OP_W]) == OP_HALT);

   // PC parks on a fetched HALT, only a redirect moves it on
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= target;
      end else if (!hold && !at_halt) begin
         pc <= pc + 1'b1;
      end
   end

   assign out = '{valid: 1'b1, pc: pc, instr: instr};
endmodule

//--- source/pipe_latch.sv
`timescale 1ns/1ns
/*
 * Pipeline register between two stages, with hold and flush
 */
module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     hold,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);
   // Flush beats hold
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         q <= '0;
      end else if (!hold) begin
         q <= d;
      end
   end
endmodule

//--- source/hazard_if.sv
`timescale 1ns/1ns
/*
 * Forwarding and hazard signals between decode, execute and the hazard unit
 */
interface hazard_if;
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   reg_idx_t id_ra;
   reg_idx_t id_rb;
   reg_idx_t ex_ra;
   reg_idx_t ex_rb;
   logic     ex_load;
   reg_idx_t ex_dest;
   reg_idx_t mem_dest;
   logic     mem_write;
   reg_idx_t wb_dest;
   logic     wb_write;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;
   logic     stall;

   modport unit (
      input  id_ra, id_rb, ex_ra, ex_rb, ex_load, ex_dest,
      input  mem_dest, mem_write, wb_dest, wb_write,
      output fwd_a, fwd_b, stall
   );
   modport exec (input fwd_a, fwd_b);
   modport dec (input stall);
endinterface

//--- source/cpu_pipe_pkg.sv
/*
 * Pipeline types: control word, stage payloads, forwarding selects
 */
package cpu_pipe_pkg;
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic                  branch;
      logic                  halt;
      logic                  use_imm;
      alu_op_t               alu_op;
      cpu_isa_pkg::reg_idx_t dest;
   } ctrl_t;

   // All-zero payload is a bubble
   typedef struct packed {
      logic                    valid;
      cpu_isa_pkg::imem_addr_t pc;
      cpu_isa_pkg::word_t      instr;
   } if_id_t;

   typedef struct packed {
      logic                    valid;
      cpu_isa_pkg::imem_addr_t pc;
      ctrl_t                   ctrl;
      cpu_isa_pkg::reg_idx_t   ra;
      cpu_isa_pkg::reg_idx_t   rb;
      cpu_isa_pkg::word_t      a_val;
      cpu_isa_pkg::word_t      b_val;
      cpu_isa_pkg::word_t      imm;
   } id_ex_t;

   typedef struct packed {
      logic               valid;
      ctrl_t              ctrl;
      cpu_isa_pkg::word_t result;
      cpu_isa_pkg::word_t store_val;
   } ex_mem_t;

   typedef struct packed {
      logic               valid;
      ctrl_t              ctrl;
      cpu_isa_pkg::word_t result;
      cpu_isa_pkg::word_t load_val;
   } mem_wb_t;

   typedef enum logic [1:0] {
      FWD_RF,
      FWD_MEM,
      FWD_WB
   } fwd_sel_t;
endpackage

//--- source/cpu_isa_pkg.sv
/*
 * Instruction set of the 16-bit pipelined core
 * Word types, opcodes, field positions and memory sizes
 */
package cpu_isa_pkg;
   localparam int WORD_W     = 16;
   localparam int REG_W      = 3;
   localparam int NUM_REGS   = 8;
   localparam int OP_W       = 4;
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;

   // Instruction field positions
   localparam int OP_LSB = 12;
   localparam int FA_LSB = 9;
   localparam int FB_LSB = 6;
   localparam int FD_LSB = 3;
   localparam int IMM_W  = 6;
   localparam int OFF_W  = 9;

   typedef logic [WORD_W-1:0]              word_t;
   typedef logic [REG_W-1:0]               reg_idx_t;
   typedef logic [$clog2(IMEM_DEPTH)-1:0]  imem_addr_t;
   typedef logic [$clog2(DMEM_DEPTH)-1:0]  dmem_addr_t;

   typedef enum logic [OP_W-1:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7,
      OP_BEQZ = 4'd8,
      OP_HALT = 4'd15
   } opcode_t;
endpackage
